/* hw/u2_ctrl_macros.svh */
// Address map and sizes of the control-plane bus
// Windows decode on byte address bits 15:10, RAM on bit 15 alone
`ifndef U2_CTRL_MACROS_SVH
`define U2_CTRL_MACROS_SVH

//////////////////////////////////////////////////
// Bus widths
`define U2_DW 32
`define U2_AW 16
`define U2_SW 4

// RAM array word address, 1024 words
`define U2_RAM_AW 10

//////////////////////////////////////////////////
// Slave windows
// Bit 15 low selects the RAM
`define U2_WIN_RAM_MSB 1'b0
// Readback words at 0xCC00
`define U2_WIN_STATUS 6'b110011
// Settings bus at 0xD400
`define U2_WIN_SETTINGS 6'b110101
// Interrupt controller at 0xD800
`define U2_WIN_PIC 6'b110110

//////////////////////////////////////////////////
// Setting register numbers
`define U2_SR_CLK 8'd0
`define U2_SR_ADC 8'd2
`define U2_SR_LED 8'd3
`define U2_SR_PHY 8'd4
`define U2_SR_LED_SRC 8'd8

// Interrupt sources, ext lines plus clk_status
`define U2_IRQ_W 9

`endif

/* hw/u2_ctrl_pkg.sv */
// Bus address and settings word views
// Taken by scoped name only, widths come from the macro header
`default_nettype none
`include "u2_ctrl_macros.svh"

package u2_ctrl_pkg;

   // RAM view, bit 15 then word index then byte lane
   typedef struct packed {
      logic                 pad;
      logic [`U2_AW-4:0]    word;
      logic [1:0]           byte_off;
   } ram_addr_t;

   // Peripheral view, window code and register number
   typedef struct packed {
      logic [5:0]           win;
      logic [7:0]           num;
      logic [1:0]           byte_off;
   } io_addr_t;

   typedef union packed {
      ram_addr_t            ram;
      io_addr_t             io;
   } wb_addr_u;

   // Clock register layout, low five bits
   typedef struct packed {
      logic [`U2_DW-6:0]    unused;
      logic                 clock_ready;
      logic [1:0]           clk_en;
      logic [1:0]           clk_sel;
   } clk_word_t;

   // ADC register layout, low four bits
   typedef struct packed {
      logic [`U2_DW-5:0]    unused;
      logic                 adc_oe_a;
      logic                 adc_on_a;
      logic                 adc_oe_b;
      logic                 adc_on_b;
   } adc_word_t;

   typedef union packed {
      clk_word_t            clk;
      adc_word_t            adc;
      logic [`U2_DW-1:0]    raw;
   } settings_word_u;

endpackage

`default_nettype wire

/* hw/wb_slave_decode.sv */
// Single-master decoder, one access outstanding at a time
// Unmapped windows get a one-cycle err, never an ack
`default_nettype none
`include "u2_ctrl_macros.svh"

module wb_slave_decode (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  u2_ctrl_pkg::wb_addr_u wb_adr_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_cyc_i,
   input  logic                  ram_ack_i,
   input  logic [`U2_DW-1:0]     ram_dat_i,
   input  logic                  set_ack_i,
   input  logic [`U2_DW-1:0]     set_dat_i,
   input  logic                  status_ack_i,
   input  logic [`U2_DW-1:0]     status_dat_i,
   input  logic                  pic_ack_i,
   input  logic [`U2_DW-1:0]     pic_dat_i,
   output logic                  ram_stb_o,
   output logic                  set_stb_o,
   output logic                  status_stb_o,
   output logic                  pic_stb_o,
   output logic [`U2_DW-1:0]     wb_dat_o,
   output logic                  wb_ack_o,
   output logic                  wb_err_o
);

   logic hit;
   logic is_ram, is_set, is_status, is_pic;
   logic err_q;

   assign hit = wb_stb_i & wb_cyc_i;

   // Window match, io codes all have bit 15 set
   assign is_ram    = (wb_adr_i.ram.pad == `U2_WIN_RAM_MSB);
   assign is_set    = (wb_adr_i.io.win == `U2_WIN_SETTINGS);
   assign is_status = (wb_adr_i.io.win == `U2_WIN_STATUS);
   assign is_pic    = (wb_adr_i.io.win == `U2_WIN_PIC);

   assign ram_stb_o    = hit & is_ram;
   assign set_stb_o    = hit & is_set;
   assign status_stb_o = hit & is_status;
   assign pic_stb_o    = hit & is_pic;

   // Err pulse one cycle after the strobe, dropped after one cycle
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= hit & ~(is_ram | is_set | is_status | is_pic) & ~err_q;
      end
   end

   assign wb_err_o = err_q;

   //////////////////////////////////////////////////
   // Return path
   assign wb_ack_o = ram_ack_i | set_ack_i | status_ack_i | pic_ack_i;

   always_comb begin
      if (ram_ack_i)         wb_dat_o = ram_dat_i;
      else if (set_ack_i)    wb_dat_o = set_dat_i;
      else if (status_ack_i) wb_dat_o = status_dat_i;
      else                   wb_dat_o = pic_dat_i;
   end

   // Slave strobes exclusive
   a_one_stb: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      $onehot0({ram_stb_o, set_stb_o, status_stb_o, pic_stb_o}));

   // Slave acks and decoder err never overlap
   a_ack_err: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      !(wb_ack_o && wb_err_o));

endmodule

`default_nettype wire

/* hw/ram_boot_loader.sv */
// Serial boot loader, MSB first, 32 bits per word, one bit per 2 cycles max
// Words go to RAM from word 0 up; a partial word at detach is lost
`default_nettype none
`include "u2_ctrl_macros.svh"

module ram_boot_loader (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  logic                  cfg_bit_i,
   input  logic                  cfg_stb_i,
   input  logic                  cfg_detached_i,
   input  logic                  ld_ack_i,
   output logic                  ld_req_o,
   output logic [`U2_RAM_AW-1:0] ld_adr_o,
   output logic [`U2_DW-1:0]     ld_dat_o,
   output logic                  loader_done_o
);

   logic [`U2_DW-1:0] shift_q;
   logic [4:0]        bit_cnt;
   logic              word_done;

   // Last bit of a word arriving this cycle
   assign word_done = cfg_stb_i & ~loader_done_o & (bit_cnt == 5'd31);

   // Shift register and finished word, payload only
   always_ff @(posedge dsp_clk) begin
      if (cfg_stb_i) begin
         shift_q <= {shift_q[`U2_DW-2:0], cfg_bit_i};
      end
      if (word_done) begin
         ld_dat_o <= {shift_q[`U2_DW-2:0], cfg_bit_i};
      end
   end

   //////////////////////////////////////////////////
   // Control
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         bit_cnt       <= '0;
         ld_req_o      <= 1'b0;
         ld_adr_o      <= '0;
         loader_done_o <= 1'b0;
      end else begin
         // Bits ignored once detached
         if (cfg_stb_i && !loader_done_o) begin
            bit_cnt <= bit_cnt + 5'd1;
         end
         // Request holds until the RAM takes it
         if (word_done) begin
            ld_req_o <= 1'b1;
         end else if (ld_ack_i) begin
            ld_req_o <= 1'b0;
            ld_adr_o <= ld_adr_o + 1'b1;
         end
         // Done only once no write is pending or forming
         if (cfg_detached_i && !ld_req_o && !word_done) begin
            loader_done_o <= 1'b1;
         end
      end
   end

   // No RAM write after config_success
   a_done_idle: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      !(ld_req_o && loader_done_o));

endmodule

`default_nettype wire

/* hw/sys_ram.sv */
// One-port system RAM shared by the boot loader and the bus
// Loader has fixed priority, bus addresses wrap on the array size
`default_nettype none
`include "u2_ctrl_macros.svh"

module sys_ram (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  logic                  ld_req_i,
   input  logic [`U2_RAM_AW-1:0] ld_adr_i,
   input  logic [`U2_DW-1:0]     ld_dat_i,
   input  logic                  bus_stb_i,
   input  logic                  bus_we_i,
   input  logic [`U2_SW-1:0]     bus_sel_i,
   input  u2_ctrl_pkg::wb_addr_u bus_adr_i,
   input  logic [`U2_DW-1:0]     bus_dat_i,
   output logic                  ld_ack_o,
   output logic                  bus_ack_o,
   output logic [`U2_DW-1:0]     bus_dat_o
);

   logic [`U2_DW-1:0]     mem [0:(1 << `U2_RAM_AW)-1];
   logic                  ld_gnt, bus_gnt;
   logic [`U2_RAM_AW-1:0] ram_adr;
   logic [`U2_DW-1:0]     ram_wdat;
   logic [`U2_SW-1:0]     ram_we;

   //////////////////////////////////////////////////
   // Arbiter
   // Requests stay up through their ack cycle, so mask a second grant
   assign ld_gnt  = ld_req_i & ~ld_ack_o;
   assign bus_gnt = bus_stb_i & ~bus_ack_o & ~ld_gnt;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ld_ack_o  <= 1'b0;
         bus_ack_o <= 1'b0;
      end else begin
         ld_ack_o  <= ld_gnt;
         bus_ack_o <= bus_gnt;
      end
   end

   // Port mux, loader writes are full words
   assign ram_adr  = ld_gnt ? ld_adr_i : bus_adr_i.ram.word[`U2_RAM_AW-1:0];
   assign ram_wdat = ld_gnt ? ld_dat_i : bus_dat_i;
   assign ram_we   = ld_gnt ? {`U2_SW{1'b1}} :
                     ((bus_gnt & bus_we_i) ? bus_sel_i : '0);

   //////////////////////////////////////////////////
   // Byte-writable array, registered read
   always_ff @(posedge dsp_clk) begin
      for (int b = 0; b < `U2_SW; b++) begin
         if (ram_we[b]) begin
            mem[ram_adr][8*b +: 8] <= ram_wdat[8*b +: 8];
         end
      end
      bus_dat_o <= mem[ram_adr];
   end

   // One grantee per cycle
   a_one_ack: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      !(ld_ack_o && bus_ack_o));

endmodule

`default_nettype wire

/* hw/settings_regs.sv */
// Settings bus and its setting registers, write only, reads give 0
// Outputs change in the bus ack cycle
`default_nettype none
`include "u2_ctrl_macros.svh"

module settings_regs (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  logic                  bus_stb_i,
   input  logic                  bus_we_i,
   input  u2_ctrl_pkg::wb_addr_u bus_adr_i,
   input  logic [`U2_DW-1:0]     bus_dat_i,
   input  logic                  clk_status_i,
   input  logic                  loader_done_i,
   output logic                  bus_ack_o,
   output logic [`U2_DW-1:0]     bus_dat_o,
   output logic                  clock_ready_o,
   output logic [1:0]            clk_en_o,
   output logic [1:0]            clk_sel_o,
   output logic                  adc_oe_a_o,
   output logic                  adc_on_a_o,
   output logic                  adc_oe_b_o,
   output logic                  adc_on_b_o,
   output logic                  phy_resetn_o,
   output logic [7:0]            leds_o
);

   // Slot order in sr_q
   localparam int N_SR = 5;
   localparam logic [7:0] SR_NUM [N_SR] =
      '{`U2_SR_CLK, `U2_SR_ADC, `U2_SR_LED, `U2_SR_PHY, `U2_SR_LED_SRC};

   logic                       set_stb;
   logic [7:0]                 set_addr;
   logic [`U2_DW-1:0]          sr_q [N_SR];
   u2_ctrl_pkg::settings_word_u clk_w, adc_w;
   logic [7:0]                 led_hw;

   //////////////////////////////////////////////////
   // Settings strobe, first strobe cycle of a write
   assign set_stb  = bus_stb_i & bus_we_i & ~bus_ack_o;
   assign set_addr = bus_adr_i.io.num;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         bus_ack_o <= 1'b0;
      end else begin
         bus_ack_o <= bus_stb_i & ~bus_ack_o;
      end
   end

   assign bus_dat_o = '0;

   // Each register loads on its own number
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         sr_q <= '{default: '0};
      end else if (set_stb) begin
         for (int i = 0; i < N_SR; i++) begin
            if (set_addr == SR_NUM[i]) sr_q[i] <= bus_dat_i;
         end
      end
   end

   //////////////////////////////////////////////////
   // Output decode
   assign clk_w = sr_q[0];
   assign adc_w = sr_q[1];

   assign clock_ready_o = clk_w.clk.clock_ready;
   assign clk_en_o      = clk_w.clk.clk_en;
   assign clk_sel_o     = clk_w.clk.clk_sel;
   assign adc_oe_a_o    = adc_w.adc.adc_oe_a;
   assign adc_on_a_o    = adc_w.adc.adc_on_a;
   assign adc_oe_b_o    = adc_w.adc.adc_oe_b;
   assign adc_on_b_o    = adc_w.adc.adc_on_b;

   // Register holds reset, line is active low
   assign phy_resetn_o = ~sr_q[3][0];

   // LEDs, led_src 1 picks hardware, 0 picks led_sw
   assign led_hw = {6'b0, clk_status_i, loader_done_i};
   assign leds_o = (sr_q[4][7:0] & led_hw) | (~sr_q[4][7:0] & sr_q[2][7:0]);

endmodule

`default_nettype wire

/* hw/status_irq_ctrl.sv */
// Interrupt controller and readback status words
// Pending bits latch rising edges, write 1 to clear
`default_nettype none
`include "u2_ctrl_macros.svh"

module status_irq_ctrl (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  logic                  status_stb_i,
   input  logic                  pic_stb_i,
   input  logic                  bus_we_i,
   input  u2_ctrl_pkg::wb_addr_u bus_adr_i,
   input  logic [`U2_DW-1:0]     bus_dat_i,
   input  logic [7:0]            ext_irq_i,
   input  logic                  clk_status_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   output logic                  status_ack_o,
   output logic [`U2_DW-1:0]     status_dat_o,
   output logic                  pic_ack_o,
   output logic [`U2_DW-1:0]     pic_dat_o,
   output logic                  int_o
);

   logic [`U2_IRQ_W-1:0] irq, irq_q, mask_q, pend_q, pend_clr;
   logic                 pic_wr;
   logic [`U2_DW-1:0]    prio, cycle_cnt, status_word;

   assign irq = {clk_status_i, ext_irq_i};

   //////////////////////////////////////////////////
   // Interrupt controller
   assign pic_wr   = pic_stb_i & ~pic_ack_o & bus_we_i;
   assign pend_clr = (pic_wr && bus_adr_i.io.num == 8'd1) ?
                     bus_dat_i[`U2_IRQ_W-1:0] : '0;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         irq_q     <= '0;
         mask_q    <= '0;
         pend_q    <= '0;
         pic_ack_o <= 1'b0;
      end else begin
         irq_q     <= irq;
         pic_ack_o <= pic_stb_i & ~pic_ack_o;
         // New edge wins over a clear in the same cycle
         pend_q    <= (pend_q & ~pend_clr) | (irq & ~irq_q);
         if (pic_wr && bus_adr_i.io.num == 8'd0) begin
            mask_q <= bus_dat_i[`U2_IRQ_W-1:0];
         end
      end
   end

   assign int_o = |(pend_q & mask_q);

   // PIC read data
   always_ff @(posedge dsp_clk) begin
      case (bus_adr_i.io.num)
         8'd0:    pic_dat_o <= `U2_DW'(mask_q);
         8'd1:    pic_dat_o <= `U2_DW'(pend_q);
         default: pic_dat_o <= '0;
      endcase
   end

   // Lowest pending bit, all ones when idle
   always_comb begin
      prio = '1;
      for (int i = `U2_IRQ_W - 1; i >= 0; i--) begin
         if (pend_q[i]) prio = `U2_DW'(i);
      end
   end

   //////////////////////////////////////////////////
   // Readback words
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_cnt    <= '0;
         status_ack_o <= 1'b0;
      end else begin
         cycle_cnt    <= cycle_cnt + 1'b1;
         status_ack_o <= status_stb_i & ~status_ack_o;
      end
   end

   always_comb begin
      case (bus_adr_i.io.num)
         8'd9:    status_word = {sim_mode_i, 27'b0, clock_divider_i};
         8'd13:   status_word = `U2_DW'(irq);
         8'd14:   status_word = prio;
         8'd15:   status_word = cycle_cnt;
         default: status_word = '0;
      endcase
   end

   // Sampled with the ack
   always_ff @(posedge dsp_clk) begin
      status_dat_o <= status_word;
   end

endmodule

`default_nettype wire

/* hw/u2_ctrl_top.sv */
// Control plane of the radio core, single clock dsp_clk
// External master holds its request until ack or err
`default_nettype none
`include "u2_ctrl_macros.svh"

module u2_ctrl_top (
   input  logic              dsp_clk,
   input  logic              wb_rst,
   input  logic [`U2_AW-1:0] wb_adr_i,
   input  logic [`U2_DW-1:0] wb_dat_i,
   input  logic [`U2_SW-1:0] wb_sel_i,
   input  logic              wb_we_i,
   input  logic              wb_stb_i,
   input  logic              wb_cyc_i,
   input  logic              cfg_bit_i,
   input  logic              cfg_stb_i,
   input  logic              cfg_detached_i,
   input  logic [7:0]        ext_irq_i,
   input  logic              clk_status_i,
   input  logic              sim_mode_i,
   input  logic [3:0]        clock_divider_i,
   output logic [`U2_DW-1:0] wb_dat_o,
   output logic              wb_ack_o,
   output logic              wb_err_o,
   output logic              config_success_o,
   output logic              int_o,
   output logic [7:0]        leds_o,
   output logic              clock_ready_o,
   output logic [1:0]        clk_en_o,
   output logic [1:0]        clk_sel_o,
   output logic              adc_oe_a_o,
   output logic              adc_on_a_o,
   output logic              adc_oe_b_o,
   output logic              adc_on_b_o,
   output logic              phy_resetn_o
);

   logic                  ram_stb, set_stb_bus, status_stb, pic_stb;
   logic                  ram_ack, set_ack, status_ack, pic_ack;
   logic [`U2_DW-1:0]     ram_dat, set_dat, status_dat, pic_dat;
   logic                  ld_req, ld_ack;
   logic [`U2_RAM_AW-1:0] ld_adr;
   logic [`U2_DW-1:0]     ld_dat;

   //////////////////////////////////////////////////
   // Bus decode
   wb_slave_decode decode (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i),
      .wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i),
      .ram_ack_i(ram_ack), .ram_dat_i(ram_dat),
      .set_ack_i(set_ack), .set_dat_i(set_dat),
      .status_ack_i(status_ack), .status_dat_i(status_dat),
      .pic_ack_i(pic_ack), .pic_dat_i(pic_dat),
      .ram_stb_o(ram_stb), .set_stb_o(set_stb_bus),
      .status_stb_o(status_stb), .pic_stb_o(pic_stb),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o));

   // Boot loader, done flag is config_success
   ram_boot_loader loader (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .cfg_bit_i(cfg_bit_i),
      .cfg_stb_i(cfg_stb_i), .cfg_detached_i(cfg_detached_i), .ld_ack_i(ld_ack),
      .ld_req_o(ld_req), .ld_adr_o(ld_adr), .ld_dat_o(ld_dat),
      .loader_done_o(config_success_o));

   // Shared RAM
   sys_ram ram (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .ld_req_i(ld_req), .ld_adr_i(ld_adr), .ld_dat_i(ld_dat),
      .bus_stb_i(ram_stb), .bus_we_i(wb_we_i), .bus_sel_i(wb_sel_i),
      .bus_adr_i(wb_adr_i), .bus_dat_i(wb_dat_i),
      .ld_ack_o(ld_ack), .bus_ack_o(ram_ack), .bus_dat_o(ram_dat));

   //////////////////////////////////////////////////
   // Peripherals
   settings_regs settings (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .bus_stb_i(set_stb_bus), .bus_we_i(wb_we_i),
      .bus_adr_i(wb_adr_i), .bus_dat_i(wb_dat_i), .clk_status_i(clk_status_i),
      .loader_done_i(config_success_o), .bus_ack_o(set_ack), .bus_dat_o(set_dat),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_resetn_o(phy_resetn_o), .leds_o(leds_o));

   status_irq_ctrl status (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .status_stb_i(status_stb),
      .pic_stb_i(pic_stb), .bus_we_i(wb_we_i), .bus_adr_i(wb_adr_i),
      .bus_dat_i(wb_dat_i), .ext_irq_i(ext_irq_i), .clk_status_i(clk_status_i),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .status_ack_o(status_ack), .status_dat_o(status_dat),
      .pic_ack_o(pic_ack), .pic_dat_o(pic_dat), .int_o(int_o));

endmodule

`default_nettype wire

/* tb/u2_ctrl_tb.sv */
// Directed testbench for the control-plane top level
// Inputs change on the rising edge, responses are sampled on the falling edge
// Tests share DUT state and run in a fixed order
`default_nettype none
`include "u2_ctrl_macros.svh"

module u2_ctrl_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD = 20;
   localparam int RST_CYC    = 10;
   localparam int BOOT_WORDS = 8;
   localparam int BUS_LIMIT  = 64;
   localparam int GAP        = 10;
   localparam int PROBE_WORD = 512;
   localparam int RAM_WORD   = 20;
   localparam logic [31:0] PROBE_DAT = 32'hA5A5_0F0F;
   // Boot stream at one bit per 2 cycles, then the bus tests
   localparam int TEST_CYC   = RST_CYC + BOOT_WORDS * `U2_DW * 2 + 800;

   logic              dsp_clk, wb_rst;
   logic [`U2_AW-1:0] wb_adr_i;
   logic [`U2_DW-1:0] wb_dat_i, wb_dat_o;
   logic [`U2_SW-1:0] wb_sel_i;
   logic              wb_we_i, wb_stb_i, wb_cyc_i, wb_ack_o, wb_err_o;
   logic              cfg_bit_i, cfg_stb_i, cfg_detached_i, config_success_o;
   logic [7:0]        ext_irq_i, leds_o;
   logic              clk_status_i, sim_mode_i, int_o;
   logic [3:0]        clock_divider_i;
   logic              clock_ready_o, phy_resetn_o;
   logic [1:0]        clk_en_o, clk_sel_o;
   logic              adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;

   logic [15:0] lfsr_q;
   int          n_err, n_checks, n_tests, err_mark, last_lat;
   logic [1:0]  last_resp;

   u2_ctrl_top uut (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   // Watchdog, twice the expected run length
   initial begin
      #(TEST_CYC * 2 * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("sim failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // Stimulus helpers
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task rand_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         val = {val[30:0], lfsr_q[0]};
      end
   endtask

   function automatic logic [15:0] ram_adr(input int w);
      return 16'(w * 4);
   endfunction

   function automatic logic [15:0] io_adr(input logic [5:0] win, input logic [7:0] num);
      return {win, num, 2'b00};
   endfunction

   task check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_err++;
         $display("error at %0d ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task report_test(input string name);
      n_tests++;
      if (n_err == err_mark) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, n_err - err_mark);
      err_mark = n_err;
   endtask

   //////////////////////////////////////////////////
   // Bus master, holds the request until ack or err
   task do_access(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                  input logic [3:0] sel, output logic [31:0] rdat);
      int n;
      n = 0;
      @(posedge dsp_clk);
      wb_adr_i <= adr;
      wb_dat_i <= dat;
      wb_sel_i <= sel;
      wb_we_i  <= we;
      wb_stb_i <= 1'b1;
      wb_cyc_i <= 1'b1;
      @(negedge dsp_clk);
      while (!(wb_ack_o || wb_err_o) && n < BUS_LIMIT) begin
         n++;
         @(negedge dsp_clk);
      end
      if (n >= BUS_LIMIT) begin
         n_err++;
         $display("bus access to %h got neither ack nor err", adr);
      end
      rdat      = wb_dat_o;
      last_resp = {wb_ack_o, wb_err_o};
      last_lat  = n;
      @(posedge dsp_clk);
      wb_stb_i <= 1'b0;
      wb_cyc_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task write_word(input logic [15:0] adr, input logic [31:0] dat, input logic [3:0] sel);
      logic [31:0] unused;
      do_access(1'b1, adr, dat, sel, unused);
      check_eq(last_resp, 2'b10, "write response");
   endtask

   task read_word(input logic [15:0] adr, output logic [31:0] rdat);
      do_access(1'b0, adr, '0, 4'hF, rdat);
      check_eq(last_resp, 2'b10, "read response");
   endtask

   //////////////////////////////////////////////////
   // Tests
   // Serial boot image into RAM, bus reads racing the loader
   task load_boot_image();
      logic [31:0] words [BOOT_WORDS];
      logic [31:0] rdat;
      logic        stream_done;
      int          n;
      int          n_late;
      write_word(ram_adr(PROBE_WORD), PROBE_DAT, 4'hF);
      for (int i = 0; i < BOOT_WORDS; i++) rand_bits(32, words[i]);
      stream_done = 1'b0;
      n_late = 0;
      fork
         begin
            for (int i = 0; i < BOOT_WORDS; i++) begin
               for (int b = 31; b >= 0; b--) begin
                  @(posedge dsp_clk);
                  cfg_stb_i <= 1'b1;
                  cfg_bit_i <= words[i][b];
                  @(posedge dsp_clk);
                  cfg_stb_i <= 1'b0;
               end
            end
            stream_done = 1'b1;
         end
         begin
            while (!stream_done) begin
               read_word(ram_adr(PROBE_WORD), rdat);
               check_eq(rdat, PROBE_DAT, "RAM read during boot load");
               // Loader took the port first
               if (last_lat > 1) n_late++;
            end
         end
      join
      check_eq(n_late > 0, 1'b1, "a bus read waited behind a loader write");
      @(posedge dsp_clk);
      cfg_detached_i <= 1'b1;
      n = 0;
      @(negedge dsp_clk);
      while (!config_success_o && n < BUS_LIMIT) begin
         n++;
         @(negedge dsp_clk);
      end
      check_eq(config_success_o, 1'b1, "config_success after detach");
      for (int i = 0; i < BOOT_WORDS; i++) begin
         read_word(ram_adr(i), rdat);
         check_eq(rdat, words[i], "boot word in RAM");
      end
   endtask

   task access_ram();
      logic [31:0] exp, dat, rdat, mask, tmp;
      rand_bits(32, exp);
      write_word(ram_adr(RAM_WORD), exp, 4'hF);
      check_eq(last_lat, 1, "RAM ack latency with loader idle");
      read_word(ram_adr(RAM_WORD), rdat);
      check_eq(rdat, exp, "RAM full-word readback");
      for (int k = 0; k < 4; k++) begin
         rand_bits(32, dat);
         rand_bits(4, tmp);
         for (int b = 0; b < 4; b++) mask[8*b +: 8] = {8{tmp[b]}};
         // Only selected bytes change
         exp = (exp & ~mask) | (dat & mask);
         write_word(ram_adr(RAM_WORD), dat, tmp[3:0]);
         read_word(ram_adr(RAM_WORD), rdat);
         check_eq(rdat, exp, "RAM byte-select merge");
      end
      // Window wraps on the array size
      read_word(ram_adr(RAM_WORD + (1 << `U2_RAM_AW)), rdat);
      check_eq(rdat, exp, "RAM address wrap");
   endtask

   task program_settings();
      u2_ctrl_pkg::settings_word_u sw;
      logic [31:0] led_sw, led_src, rdat;
      logic [7:0]  hw_src;
      logic [7:0]  exp_led;
      rand_bits(32, sw.raw);
      write_word(io_adr(`U2_WIN_SETTINGS, `U2_SR_CLK), sw.raw, 4'hF);
      check_eq(last_lat, 1, "settings ack latency");
      @(negedge dsp_clk);
      check_eq(clock_ready_o, sw.clk.clock_ready, "clock_ready_o");
      check_eq(clk_en_o, sw.clk.clk_en, "clk_en_o");
      check_eq(clk_sel_o, sw.clk.clk_sel, "clk_sel_o");
      rand_bits(32, sw.raw);
      write_word(io_adr(`U2_WIN_SETTINGS, `U2_SR_ADC), sw.raw, 4'hF);
      @(negedge dsp_clk);
      check_eq(adc_oe_a_o, sw.adc.adc_oe_a, "adc_oe_a_o");
      check_eq(adc_on_a_o, sw.adc.adc_on_a, "adc_on_a_o");
      check_eq(adc_oe_b_o, sw.adc.adc_oe_b, "adc_oe_b_o");
      check_eq(adc_on_b_o, sw.adc.adc_on_b, "adc_on_b_o");
      // PHY reset line is active low
      write_word(io_adr(`U2_WIN_SETTINGS, `U2_SR_PHY), 32'd1, 4'hF);
      @(negedge dsp_clk);
      check_eq(phy_resetn_o, 1'b0, "phy_resetn_o with reset set");
      write_word(io_adr(`U2_WIN_SETTINGS, `U2_SR_PHY), 32'd0, 4'hF);
      @(negedge dsp_clk);
      check_eq(phy_resetn_o, 1'b1, "phy_resetn_o with reset cleared");
      rand_bits(8, led_sw);
      rand_bits(8, led_src);
      write_word(io_adr(`U2_WIN_SETTINGS, `U2_SR_LED), led_sw, 4'hF);
      write_word(io_adr(`U2_WIN_SETTINGS, `U2_SR_LED_SRC), led_src, 4'hF);
      @(negedge dsp_clk);
      // Loader finished in the boot test
      hw_src = {6'b0, clk_status_i, 1'b1};
      for (int b = 0; b < 8; b++) begin
         exp_led[b] = led_src[b] ? hw_src[b] : led_sw[b];
      end
      check_eq(leds_o, exp_led, "leds_o mix");
      read_word(io_adr(`U2_WIN_SETTINGS, `U2_SR_CLK), rdat);
      check_eq(rdat, 32'd0, "settings read data");
   endtask

   task read_status_words();
      logic [31:0] rdat, c0, c1, irq_val;
      logic [31:0] exp_word;
      read_word(io_adr(`U2_WIN_STATUS, 8'd9), rdat);
      check_eq(last_lat, 1, "status ack latency");
      exp_word       = '0;
      exp_word[31]   = sim_mode_i;
      exp_word[3:0]  = clock_divider_i;
      check_eq(rdat, exp_word, "status word 9");
      read_word(io_adr(`U2_WIN_STATUS, 8'd15), c0);
      repeat (GAP) @(posedge dsp_clk);
      read_word(io_adr(`U2_WIN_STATUS, 8'd15), c1);
      check_eq(((c1 - c0) >= GAP) ? 32'd1 : 32'd0, 32'd1, "cycle counter advance");
      rand_bits(8, irq_val);
      @(posedge dsp_clk);
      ext_irq_i <= irq_val[7:0];
      read_word(io_adr(`U2_WIN_STATUS, 8'd13), rdat);
      check_eq(rdat, {23'b0, clk_status_i, irq_val[7:0]}, "status word 13");
      @(posedge dsp_clk);
      ext_irq_i <= 8'h00;
   endtask

   task exercise_interrupts();
      logic [31:0] rdat;
      // Drop edges latched by earlier tests
      write_word(io_adr(`U2_WIN_PIC, 8'd1), 32'h1FF, 4'hF);
      write_word(io_adr(`U2_WIN_PIC, 8'd0), 32'h008, 4'hF);
      check_eq(last_lat, 1, "PIC ack latency");
      read_word(io_adr(`U2_WIN_STATUS, 8'd14), rdat);
      check_eq(rdat, 32'hFFFF_FFFF, "priority word with nothing pending");
      @(posedge dsp_clk);
      ext_irq_i <= 8'h08;
      @(negedge dsp_clk);
      check_eq(int_o, 1'b0, "int_o before the edge latches");
      @(posedge dsp_clk);
      ext_irq_i <= 8'h00;
      @(negedge dsp_clk);
      check_eq(int_o, 1'b1, "int_o after enabled source edge");
      read_word(io_adr(`U2_WIN_PIC, 8'd1), rdat);
      check_eq(rdat, 32'h008, "pending register");
      read_word(io_adr(`U2_WIN_STATUS, 8'd14), rdat);
      check_eq(rdat, 32'd3, "priority word");
      write_word(io_adr(`U2_WIN_PIC, 8'd1), 32'h008, 4'hF);
      @(negedge dsp_clk);
      check_eq(int_o, 1'b0, "int_o after clear");
      // Masked source
      @(posedge dsp_clk);
      ext_irq_i <= 8'h20;
      @(posedge dsp_clk);
      ext_irq_i <= 8'h00;
      repeat (3) @(negedge dsp_clk);
      check_eq(int_o, 1'b0, "int_o with masked source");
      read_word(io_adr(`U2_WIN_PIC, 8'd1), rdat);
      check_eq(rdat, 32'h020, "pending bit of masked source");
   endtask

   task probe_unmapped();
      logic [31:0] rdat, dat;
      do_access(1'b0, 16'hE000, '0, 4'hF, rdat);
      check_eq(last_resp, 2'b01, "unmapped window gives err only");
      check_eq(last_lat, 1, "err latency");
      rand_bits(32, dat);
      write_word(ram_adr(RAM_WORD + 1), dat, 4'hF);
      read_word(ram_adr(RAM_WORD + 1), rdat);
      check_eq(rdat, dat, "RAM access after err");
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   initial begin
      lfsr_q   = 16'd60;
      n_err    = 0;
      n_checks = 0;
      n_tests  = 0;
      err_mark = 0;
      wb_rst          <= 1'b1;
      wb_adr_i        <= '0;
      wb_dat_i        <= '0;
      wb_sel_i        <= '0;
      wb_we_i         <= 1'b0;
      wb_stb_i        <= 1'b0;
      wb_cyc_i        <= 1'b0;
      cfg_bit_i       <= 1'b0;
      cfg_stb_i       <= 1'b0;
      cfg_detached_i  <= 1'b0;
      ext_irq_i       <= 8'h00;
      clk_status_i    <= 1'b1;
      sim_mode_i      <= 1'b1;
      clock_divider_i <= 4'hA;
      repeat (RST_CYC) @(posedge dsp_clk);
      wb_rst <= 1'b0;
      @(negedge dsp_clk);
      check_eq({wb_ack_o, wb_err_o, config_success_o, int_o, clock_ready_o, clk_en_o,
                clk_sel_o, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, leds_o},
               '0, "outputs after reset");
      check_eq(phy_resetn_o, 1'b1, "phy_resetn_o after reset");
      load_boot_image();
      report_test("boot load");
      access_ram();
      report_test("RAM access");
      program_settings();
      report_test("settings");
      read_status_words();
      report_test("readback");
      exercise_interrupts();
      report_test("interrupts");
      probe_unmapped();
      report_test("unmapped");
      $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_err);
      if (n_err == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* u2_ctrl.f */
+incdir+hw
hw/u2_ctrl_pkg.sv
hw/wb_slave_decode.sv
hw/ram_boot_loader.sv
hw/sys_ram.sv
hw/settings_regs.sv
hw/status_irq_ctrl.sv
hw/u2_ctrl_top.sv
tb/u2_ctrl_tb.sv

/* Bender.yml */
package:
  name: u2_ctrl

sources:
  - include_dirs:
      - hw
    files:
      - hw/u2_ctrl_pkg.sv
      - hw/wb_slave_decode.sv
      - hw/ram_boot_loader.sv
      - hw/sys_ram.sv
      - hw/settings_regs.sv
      - hw/status_irq_ctrl.sv
      - hw/u2_ctrl_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/u2_ctrl_tb.sv
